// File: source/chess_eval_pkg.sv
`default_nettype none

package chess_eval_pkg;

   // -------------------------------------------------------------------------
   // Square codes.
   // -------------------------------------------------------------------------

   localparam int PIECE_WIDTH = 4;

   // Bit 3 marks a black piece; bits 2:0 give the kind.
   typedef enum logic [PIECE_WIDTH-1:0]
   {
      EMPTY        = 4'd0,
      WHITE_PAWN   = 4'd1,
      WHITE_KNIGHT = 4'd2,
      WHITE_BISHOP = 4'd3,
      WHITE_ROOK   = 4'd4,
      WHITE_QUEEN  = 4'd5,
      WHITE_KING   = 4'd6,
      BLACK_PAWN   = 4'd9,
      BLACK_KNIGHT = 4'd10,
      BLACK_BISHOP = 4'd11,
      BLACK_ROOK   = 4'd12,
      BLACK_QUEEN  = 4'd13,
      BLACK_KING   = 4'd14
   } piece_t;

   // -------------------------------------------------------------------------
   // Material values and score words.
   // -------------------------------------------------------------------------

   localparam int VALUE_PAWN   = 100;
   localparam int VALUE_KNIGHT = 310;
   localparam int VALUE_BISHOP = 320;
   localparam int VALUE_ROOK   = 500;
   localparam int VALUE_QUEEN  = 900;
   localparam int VALUE_KING   = 10000;

   // Holds plus or minus one king.
   localparam int SCORE_WIDTH = 15;

   typedef logic signed [SCORE_WIDTH-1:0] square_score_t;

   typedef square_score_t square_scores_t [8][8];

   // Square index is rank * 8 + file, square 0 in the low nibble.
   typedef union packed
   {
      piece_t [63:0]     squares;
      piece_t [7:0][7:0] ranks;
   } board_t;

   function automatic square_score_t piece_value(piece_t piece);
      logic [PIECE_WIDTH-1:0] code;
      square_score_t          magnitude;
      code = piece;
      case (code[2:0])
         3'd1:    magnitude = square_score_t'(VALUE_PAWN);
         3'd2:    magnitude = square_score_t'(VALUE_KNIGHT);
         3'd3:    magnitude = square_score_t'(VALUE_BISHOP);
         3'd4:    magnitude = square_score_t'(VALUE_ROOK);
         3'd5:    magnitude = square_score_t'(VALUE_QUEEN);
         3'd6:    magnitude = square_score_t'(VALUE_KING);
         // Empty and the unused kinds 0 and 7.
         default: magnitude = '0;
      endcase
      return code[3] ? -magnitude : magnitude;
   endfunction

endpackage

`default_nettype wire

// File: source/eval_ctrl_if.sv
`default_nettype none

// Stage enables from the sequencer to the datapath.
interface eval_ctrl_if;

   logic load_board;
   logic score_en;
   logic sum_rank_en;
   logic sum_pair_en;
   logic total_en;

   modport sequencer
   (
      output load_board,
      output score_en,
      output sum_rank_en,
      output sum_pair_en,
      output total_en
   );

   modport value_stage (input load_board, input score_en);

   modport adder (input sum_rank_en, input sum_pair_en, input total_en);

endinterface

`default_nettype wire

// File: source/eval_sequencer.sv
`default_nettype none

module eval_sequencer
(
   input  logic              clk,
   input  logic              reset,
   input  logic              board_valid,
   input  logic              clear_eval,
   eval_ctrl_if.sequencer    ctrl,
   output logic              eval_valid
);

   localparam logic [2:0] ST_IDLE     = 3'd0;
   localparam logic [2:0] ST_SCORE    = 3'd1;
   localparam logic [2:0] ST_SUM_RANK = 3'd2;
   localparam logic [2:0] ST_SUM_PAIR = 3'd3;
   localparam logic [2:0] ST_DONE     = 3'd4;

   logic [2:0] state;
   logic       load_board;
   logic       total_en;

   // -------------------------------------------------------------------------
   // Stage strobes, one cycle each.
   // -------------------------------------------------------------------------

   // The board is taken at the same edge that sees board_valid.
   assign load_board = (state == ST_IDLE) && board_valid;

   // First cycle of DONE only; eval_valid marks that the total is in.
   assign total_en = (state == ST_DONE) && !eval_valid;

   assign ctrl.load_board  = load_board;
   assign ctrl.score_en    = (state == ST_SCORE);
   assign ctrl.sum_rank_en = (state == ST_SUM_RANK);
   assign ctrl.sum_pair_en = (state == ST_SUM_PAIR);
   assign ctrl.total_en    = total_en;

   // -------------------------------------------------------------------------
   // State machine.
   // -------------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state      <= ST_IDLE;
         eval_valid <= 1'b0;
      end
      else
      begin
         case (state)
            ST_IDLE:
            begin
               if (load_board)
               begin
                  state <= ST_SCORE;
               end
            end
            ST_SCORE:
            begin
               state <= ST_SUM_RANK;
            end
            ST_SUM_RANK:
            begin
               state <= ST_SUM_PAIR;
            end
            ST_SUM_PAIR:
            begin
               state <= ST_DONE;
            end
            ST_DONE:
            begin
               // Result is held until the host clears it.
               if (total_en)
               begin
                  eval_valid <= 1'b1;
               end
               else if (clear_eval)
               begin
                  state      <= ST_IDLE;
                  eval_valid <= 1'b0;
               end
            end
            default:
            begin
               state      <= ST_IDLE;
               eval_valid <= 1'b0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/square_value_stage.sv
`default_nettype none

module square_value_stage
(
   input  logic                           clk,
   input  chess_eval_pkg::board_t         board_in,
   eval_ctrl_if.value_stage               ctrl,
   output chess_eval_pkg::square_scores_t scores
);

   chess_eval_pkg::board_t board;

   // -------------------------------------------------------------------------
   // Board capture.
   // -------------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (ctrl.load_board)
      begin
         board <= board_in;
      end
   end

   // -------------------------------------------------------------------------
   // Material score of every square, all in parallel.
   // -------------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (ctrl.score_en)
      begin
         for (int r = 0; r < 8; r++)
         begin
            for (int f = 0; f < 8; f++)
            begin
               scores[r][f] <= chess_eval_pkg::piece_value(board.squares[r * 8 + f]);
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: source/score_adder_tree.sv
`default_nettype none

module score_adder_tree
#(
   parameter int EVAL_WIDTH = 22
)
(
   input  logic                                  clk,
   input  chess_eval_pkg::square_scores_t        scores,
   eval_ctrl_if.adder                            ctrl,
   output logic signed [EVAL_WIDTH-1:0]          eval
);

   // Half-rank sums, indexed by rank and half.
   logic signed [EVAL_WIDTH-1:0] sum_rank [8][2];

   // Two-rank sums.
   logic signed [EVAL_WIDTH-1:0] sum_pair [4];

   // -------------------------------------------------------------------------
   // Level 1: four squares per half rank.
   // -------------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (ctrl.sum_rank_en)
      begin
         for (int r = 0; r < 8; r++)
         begin
            for (int h = 0; h < 2; h++)
            begin
               // Widen before adding so the sign is carried.
               sum_rank[r][h] <= EVAL_WIDTH'(scores[r][4 * h + 0])
                               + EVAL_WIDTH'(scores[r][4 * h + 1])
                               + EVAL_WIDTH'(scores[r][4 * h + 2])
                               + EVAL_WIDTH'(scores[r][4 * h + 3]);
            end
         end
      end
   end

   // -------------------------------------------------------------------------
   // Level 2: two ranks per sum.
   // -------------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (ctrl.sum_pair_en)
      begin
         for (int p = 0; p < 4; p++)
         begin
            sum_pair[p] <= sum_rank[2 * p][0] + sum_rank[2 * p][1]
                         + sum_rank[2 * p + 1][0] + sum_rank[2 * p + 1][1];
         end
      end
   end

   // -------------------------------------------------------------------------
   // Level 3: board total.
   // -------------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (ctrl.total_en)
      begin
         eval <= sum_pair[0] + sum_pair[1] + sum_pair[2] + sum_pair[3];
      end
   end

endmodule

`default_nettype wire

// File: source/material_eval_top.sv
`default_nettype none

module material_eval_top
#(
   // At least 21 bits, for 64 kings.
   parameter int EVAL_WIDTH = 22
)
(
   input  logic                                       clk,
   input  logic                                       reset,
   input  logic                                       board_valid,
   input  logic [64*chess_eval_pkg::PIECE_WIDTH-1:0]  board_in,
   input  logic                                       clear_eval,
   output logic signed [EVAL_WIDTH-1:0]               eval,
   output logic                                       eval_valid
);

   localparam int PW = chess_eval_pkg::PIECE_WIDTH;

   chess_eval_pkg::board_t         board;
   chess_eval_pkg::square_scores_t scores;

   eval_ctrl_if ctrl ();

   // -------------------------------------------------------------------------
   // Flat board port onto ranks and files.
   // -------------------------------------------------------------------------

   always_comb
   begin
      for (int r = 0; r < 8; r++)
      begin
         for (int f = 0; f < 8; f++)
         begin
            board.ranks[r][f] = chess_eval_pkg::piece_t'(board_in[(r * 8 + f) * PW +: PW]);
         end
      end
   end

   // -------------------------------------------------------------------------
   // Control and datapath.
   // -------------------------------------------------------------------------

   eval_sequencer seq0
   (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .ctrl        (ctrl),
      .eval_valid  (eval_valid)
   );

   square_value_stage value0
   (
      .clk      (clk),
      .board_in (board),
      .ctrl     (ctrl),
      .scores   (scores)
   );

   score_adder_tree #(.EVAL_WIDTH(EVAL_WIDTH)) adder0
   (
      .clk    (clk),
      .scores (scores),
      .ctrl   (ctrl),
      .eval   (eval)
   );

endmodule

`default_nettype wire

// File: testbench/material_eval_tb.sv
`default_nettype none

module material_eval_tb;

   localparam int EVAL_WIDTH = 22;
   localparam int RANDOM_BOARDS = 8;

   logic                         clk;
   logic                         reset;
   logic                         board_valid;
   logic [255:0]                 board_in;
   logic                         clear_eval;
   logic signed [EVAL_WIDTH-1:0] eval;
   logic                         eval_valid;

   // Stimulus table, one slot per test.
   chess_eval_pkg::board_t tbl_board [$];
   bit                     tbl_late [$];
   int                     tbl_expect [$];
   string                  tbl_name [$];

   int errors;
   int passed;
   int failed;
   int cycle_count;
   int cycle_limit;

   material_eval_top #(.EVAL_WIDTH(EVAL_WIDTH)) dut0
   (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .board_in    (board_in),
      .clear_eval  (clear_eval),
      .eval        (eval),
      .eval_valid  (eval_valid)
   );

   always #20 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit)
      begin
         $display("Timeout after %0d cycles: the evaluator never finished", cycle_count);
         $display("TEST FAILED");
         $finish;
      end
   end

   // -------------------------------------------------------------------------
   // Reference model.
   // -------------------------------------------------------------------------

   function automatic int material(logic [3:0] code);
      case (code)
         4'd1:    return 100;
         4'd2:    return 310;
         4'd3:    return 320;
         4'd4:    return 500;
         4'd5:    return 900;
         4'd6:    return 10000;
         4'd9:    return -100;
         4'd10:   return -310;
         4'd11:   return -320;
         4'd12:   return -500;
         4'd13:   return -900;
         4'd14:   return -10000;
         default: return 0;
      endcase
   endfunction

   function automatic int ref_eval(chess_eval_pkg::board_t b);
      int sum;
      sum = 0;
      for (int s = 0; s < 64; s++)
      begin
         sum += material(b.squares[s]);
      end
      return sum;
   endfunction

   // -------------------------------------------------------------------------
   // Table setup.
   // -------------------------------------------------------------------------

   task automatic add_entry(string name, chess_eval_pkg::board_t b, bit late, int expected);
      tbl_name.push_back(name);
      tbl_board.push_back(b);
      tbl_late.push_back(late);
      tbl_expect.push_back(expected);
   endtask

   task automatic build_table();
      chess_eval_pkg::board_t b;
      logic [255:0]           flat;
      logic [3:0]             code;
      int                     sq;
      int                     back [8] = '{4, 2, 3, 5, 6, 3, 2, 4};
      int                     kind_value [6] = '{100, 310, 320, 500, 900, 10000};
      b = '0;
      add_entry("empty board", b, 1'b0, 0);
      for (int f = 0; f < 8; f++)
      begin
         b.ranks[0][f] = chess_eval_pkg::piece_t'(back[f]);
         b.ranks[1][f] = chess_eval_pkg::WHITE_PAWN;
         b.ranks[6][f] = chess_eval_pkg::BLACK_PAWN;
         b.ranks[7][f] = chess_eval_pkg::piece_t'(back[f] + 8);
      end
      add_entry("start position", b, 1'b1, 0);
      for (int k = 0; k < 12; k++)
      begin
         b = '0;
         code = (k < 6) ? 4'(k + 1) : 4'(k + 3);
         sq = (k * 23 + 7) % 64;
         b.squares[sq] = chess_eval_pkg::piece_t'(code);
         add_entry($sformatf("code %0d on square %0d", code, sq), b, k == 11,
                   (k < 6) ? kind_value[k % 6] : -kind_value[k % 6]);
      end
      // Unused codes 7, 8 and 15 over the whole board.
      for (int s = 0; s < 64; s++)
      begin
         b.squares[s] = chess_eval_pkg::piece_t'((s % 3 == 0) ? 7 : (s % 3 == 1) ? 8 : 15);
      end
      add_entry("unused codes", b, 1'b0, 0);
      b = {64{chess_eval_pkg::WHITE_QUEEN}};
      add_entry("all white queens", b, 1'b1, 57600);
      b = {64{chess_eval_pkg::BLACK_KING}};
      add_entry("all black kings", b, 1'b0, -640000);
      for (int n = 0; n < RANDOM_BOARDS; n++)
      begin
         for (int w = 0; w < 8; w++)
         begin
            flat[w * 32 +: 32] = $urandom;
         end
         b = chess_eval_pkg::board_t'(flat);
         add_entry($sformatf("random board %0d", n), b, n % 2, ref_eval(b));
      end
   endtask

   // -------------------------------------------------------------------------
   // One evaluation: capture, latency, result, optional hold, clear.
   // -------------------------------------------------------------------------

   task automatic run_entry(int idx);
      int                           edges;
      int                           errs_before;
      logic signed [EVAL_WIDTH-1:0] expect_word;
      logic signed [EVAL_WIDTH-1:0] held;
      errs_before = errors;
      expect_word = EVAL_WIDTH'(tbl_expect[idx]);
      @(negedge clk);
      board_in    = tbl_board[idx];
      board_valid = 1'b1;
      @(negedge clk);
      board_valid = 1'b0;
      edges = 0;
      while (!eval_valid)
      begin
         @(negedge clk);
         edges++;
      end
      assert (edges == 4) else
      begin
         $display("ERR eval_valid latency expected 0x4 got 0x%0h", edges);
         errors++;
      end
      assert (eval == expect_word) else
      begin
         $display("ERR eval expected 0x%06h got 0x%06h", expect_word, eval);
         errors++;
      end
      if (tbl_late[idx])
      begin
         // A new board offered while done must not disturb the result.
         held        = eval;
         board_in    = ~tbl_board[idx];
         board_valid = 1'b1;
         repeat (3)
         begin
            @(negedge clk);
            board_valid = 1'b0;
            assert (eval_valid == 1'b1) else
            begin
               $display("ERR eval_valid expected 0x1 got 0x%0h", eval_valid);
               errors++;
            end
            assert (eval == held) else
            begin
               $display("ERR eval expected 0x%06h got 0x%06h", held, eval);
               errors++;
            end
         end
      end
      clear_eval = 1'b1;
      @(negedge clk);
      clear_eval = 1'b0;
      assert (eval_valid == 1'b0) else
      begin
         $display("ERR eval_valid expected 0x0 got 0x%0h", eval_valid);
         errors++;
      end
      if (errors == errs_before)
      begin
         passed++;
         $display("test %0d %s: pass", idx, tbl_name[idx]);
      end
      else
      begin
         failed++;
         $display("test %0d %s: fail", idx, tbl_name[idx]);
      end
   endtask

   initial
   begin
      clk         = 1'b0;
      reset       = 1'b1;
      board_valid = 1'b0;
      board_in    = '0;
      clear_eval  = 1'b0;
      errors      = 0;
      passed      = 0;
      failed      = 0;
      cycle_count = 0;
      cycle_limit = 0;
      void'($urandom(35122));
      build_table();
      cycle_limit = 8 + 12 * tbl_board.size();
      repeat (8) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      assert (eval_valid == 1'b0) else
      begin
         $display("ERR eval_valid after reset expected 0x0 got 0x%0h", eval_valid);
         errors++;
      end
      for (int i = 0; i < tbl_board.size(); i++)
      begin
         run_entry(i);
      end
      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               tbl_board.size(), passed, failed, errors);
      if (errors == 0)
      begin
         $display("TEST PASSED");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
source/chess_eval_pkg.sv
source/eval_ctrl_if.sv
source/eval_sequencer.sv
source/square_value_stage.sv
source/score_adder_tree.sv
source/material_eval_top.sv
testbench/material_eval_tb.sv
